/* Bender.yml */
package:
  name: fifo_cmd_bridge

sources:
  - files:
      - rtl/cmd_pkg.sv
      - rtl/cmd_fetch.sv
      - rtl/cmd_decode.sv
      - rtl/reply_write.sv
      - rtl/fifo_cmd_bridge.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_fifo_cmd_bridge.sv

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
	output logic CLOCK_50,
	output logic rst_n
);

	// 20 ns period
	initial
	begin
		CLOCK_50 = 1'b0;
		forever
			#10 CLOCK_50 = ~CLOCK_50;
	end

	// Reset low for 8 cycles, released just after an edge
	initial
	begin
		rst_n = 1'b0;
		repeat (8) @(posedge CLOCK_50);
		#2;
		rst_n = 1'b1;
	end

endmodule

/* bench/tb_fifo_cmd_bridge.sv */
`timescale 1ns/1ns

module tb_fifo_cmd_bridge import cmd_pkg::*; ();

	// 16 echo + 8 command + 4 digit + 10 back-pressure words
	localparam int TOTAL_WORDS    = 38;
	localparam int TIMEOUT_CYCLES = TOTAL_WORDS * 8 + 200;

	logic CLOCK_50, rst_n, rx_empty, rx_read, tx_write, tx_full, start_flag;
	word_t rx_data, tx_data;
	status_arr_t status;
	seg_t digit4, digit5;

	// FIFO contents, expected and received replies
	word_t rx_q[$];
	word_t exp_q[$];
	word_t rcv_q[$];

	// Strobes seen at the falling edge, acted on after the rising edge
	logic read_seen = 1'b0;
	logic write_seen = 1'b0;
	word_t write_word;
	int read_cnt = 0;
	int value_errs = 0;
	int other_errs = 0;
	int cycle_cnt = 0;
	integer seed = 32'hf9b;

	tb_clock_gen i_tb_clock_gen (.CLOCK_50(CLOCK_50), .rst_n(rst_n));

	fifo_cmd_bridge i_fifo_cmd_bridge (
		.CLOCK_50(CLOCK_50), .rst_n(rst_n),
		.rx_empty(rx_empty), .rx_read(rx_read), .rx_data(rx_data),
		.tx_write(tx_write), .tx_data(tx_data), .tx_full(tx_full),
		.status(status), .digit4(digit4), .digit5(digit5), .start_flag(start_flag)
	);

	// ====================
	// FIFO models
	// ====================
	always @(negedge CLOCK_50)
	begin
		read_seen  = rx_read;
		write_seen = tx_write;
		write_word = tx_data;
	end

	// Word shows up on rx_data one cycle after the strobe
	always @(posedge CLOCK_50)
	begin
		#2;
		if (read_seen)
		begin
			read_cnt++;
			if (rx_q.size() > 0)
				rx_data = rx_q.pop_front();
			else
			begin
				$display("DUT read from the empty host FIFO");
				other_errs++;
			end
		end
		if (write_seen)
			rcv_q.push_back(write_word);
		rx_empty = (rx_q.size() == 0);
	end

	// Watchdog
	always @(posedge CLOCK_50)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("Run stopped: no progress after %0d cycles", cycle_cnt);
			$display("tests failed");
			$finish;
		end
	end

	// ====================
	// Helpers
	// ====================

	// Non-command random word
	function automatic word_t random_word();
		word_t w;
		w = $random(seed);
		while (w >= 20 && w <= 23)
			w = $random(seed);
		return w;
	endfunction

	// Codes 20..23 answer with a status word, all else echoes
	function automatic word_t expected_reply(input word_t w);
		if (w >= 20 && w <= 23)
			return status[w - 20];
		return w;
	endfunction

	task automatic check_value(input string name, input word_t exp, input word_t act);
		assert (act === exp)
		else
		begin
			$display("ERR %s: expected %h, actual %h", name, exp, act);
			value_errs++;
		end
	endtask

	// Queue a word between rising edges
	task automatic push_word(input word_t w);
		@(negedge CLOCK_50);
		rx_q.push_back(w);
		exp_q.push_back(expected_reply(w));
	endtask

	task automatic wait_replies(input int n);
		while (rcv_q.size() < n)
			@(negedge CLOCK_50);
	endtask

	// Count first, then order and contents
	task automatic check_replies(input string name);
		int n;
		n = exp_q.size();
		wait_replies(n);
		repeat (10) @(negedge CLOCK_50);
		assert (rcv_q.size() == n)
		else
		begin
			$display("%s: %0d replies came back for %0d words", name, rcv_q.size(), n);
			other_errs++;
		end
		for (int i = 0; i < n && i < rcv_q.size(); i++)
			check_value(name, exp_q[i], rcv_q[i]);
		exp_q.delete();
		rcv_q.delete();
	endtask

	// ====================
	// Tests
	// ====================
	task automatic test_reset();
		repeat (4)
		begin
			@(negedge CLOCK_50);
			check_value("reset rx_read", 0, rx_read);
			check_value("reset tx_write", 0, tx_write);
			check_value("reset digit4", SEG_BLANK, digit4);
			check_value("reset digit5", SEG_BLANK, digit5);
			check_value("reset start_flag", 0, start_flag);
		end
	endtask

	task automatic test_echo();
		repeat (16)
			push_word(random_word());
		check_replies("echo");
	endtask

	// Commands with echo words in between
	task automatic test_commands();
		for (int c = 20; c <= 23; c++)
		begin
			push_word(c);
			push_word(random_word());
		end
		check_replies("commands");
	endtask

	// One command at a time, indicators checked once its reply is out
	task automatic test_digits();
		check_value("digits start_flag before 20", 0, start_flag);
		push_word(OP_DIGIT4_ON);
		wait_replies(exp_q.size());
		check_value("digits 20 digit4", SEG_FULL, digit4);
		check_value("digits 20 digit5", SEG_BLANK, digit5);
		check_value("digits 20 start_flag", 1, start_flag);
		push_word(OP_DIGIT5_ON);
		wait_replies(exp_q.size());
		check_value("digits 21 digit5", SEG_FULL, digit5);
		push_word(OP_DIGIT4_OFF);
		wait_replies(exp_q.size());
		check_value("digits 22 digit4", SEG_BLANK, digit4);
		check_value("digits 22 digit5", SEG_FULL, digit5);
		push_word(OP_DIGIT5_OFF);
		wait_replies(exp_q.size());
		check_value("digits 23 digit4", SEG_BLANK, digit4);
		check_value("digits 23 digit5", SEG_BLANK, digit5);
		check_value("digits 23 start_flag", 1, start_flag);
		check_replies("digits");
	endtask

	// Pipeline holds two words at most while the host FIFO is full
	task automatic test_back_pressure();
		@(posedge CLOCK_50);
		#2;
		tx_full  = 1'b1;
		read_cnt = 0;
		repeat (10)
			push_word(random_word());
		repeat (30)
		begin
			@(negedge CLOCK_50);
			assert (tx_write == 1'b0)
			else
			begin
				$display("back_pressure: tx_write went high while tx_full was high");
				other_errs++;
			end
		end
		assert (read_cnt <= 2)
		else
		begin
			$display("back_pressure: %0d words read while tx_full was high", read_cnt);
			other_errs++;
		end
		@(posedge CLOCK_50);
		#2;
		tx_full = 1'b0;
		check_replies("back_pressure");
	endtask

	// ====================
	// Main sequence
	// ====================
	initial
	begin
		rx_empty  = 1'b1;
		rx_data   = '0;
		tx_full   = 1'b0;
		status[0] = 32'h5a7a_0020;
		status[1] = 32'h5a7a_0021;
		status[2] = 32'h5a7a_0022;
		status[3] = 32'h5a7a_0023;
		wait (rst_n === 1'b1);
		test_reset();
		test_echo();
		test_digits();
		test_commands();
		test_back_pressure();
		$display("Errors: %0d wrong values, %0d other", value_errs, other_errs);
		if (value_errs + other_errs == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* fifo_cmd_bridge.f */
rtl/cmd_pkg.sv
rtl/cmd_fetch.sv
rtl/cmd_decode.sv
rtl/reply_write.sv
rtl/fifo_cmd_bridge.sv
bench/tb_clock_gen.sv
bench/tb_fifo_cmd_bridge.sv

/* rtl/cmd_decode.sv */
`timescale 1ns/1ns

module cmd_decode import cmd_pkg::*; (
	input  logic        CLOCK_50,
	input  logic        rst_n,
	// From the input side
	input  logic        cmd_valid,
	output logic        cmd_ready,
	input  word_t       cmd_data,
	// Status words answered by the commands
	input  status_arr_t status,
	// To the output side
	output logic        reply_valid,
	input  logic        reply_ready,
	output word_t       reply_data,
	// Indicators
	output seg_t        digit4,
	output seg_t        digit5,
	output logic        start_flag
);

	// Word moves on this edge
	logic xfer;

	// Word matched a command code
	logic is_cmd;

	// Status word picked by the code
	word_t status_word;

	// ====================
	// Handshake
	// ====================

	// No storage here, the link passes straight through
	assign cmd_ready   = reply_ready;
	assign reply_valid = cmd_valid;
	assign xfer        = cmd_valid && reply_ready;

	// ====================
	// Reply select
	// ====================
	always_comb
	begin
		is_cmd      = 1'b1;
		status_word = status[0];
		case (cmd_data)
			OP_DIGIT4_ON:
				status_word = status[0];
			OP_DIGIT5_ON:
				status_word = status[1];
			OP_DIGIT4_OFF:
				status_word = status[2];
			OP_DIGIT5_OFF:
				status_word = status[3];
			default:
				is_cmd = 1'b0;
		endcase
	end

	// Anything else goes back as an echo
	assign reply_data = is_cmd ? status_word : cmd_data;

	// ====================
	// Digits and start
	// ====================

	// Updated only when the word is actually taken
	always_ff @(posedge CLOCK_50)
	begin
		if (!rst_n)
		begin
			digit4     <= SEG_BLANK;
			digit5     <= SEG_BLANK;
			start_flag <= 1'b0;
		end
		else if (xfer)
		begin
			case (cmd_data)
				OP_DIGIT4_ON:
				begin
					digit4     <= SEG_FULL;
					// Sticky until the next reset
					start_flag <= 1'b1;
				end
				OP_DIGIT5_ON:
					digit5 <= SEG_FULL;
				OP_DIGIT4_OFF:
					digit4 <= SEG_BLANK;
				OP_DIGIT5_OFF:
					digit5 <= SEG_BLANK;
				default:
					;
			endcase
		end
	end

	// Start flag only clears through reset
	a_start_sticky: assert property (@(posedge CLOCK_50)
		(rst_n && start_flag) |=> start_flag);

endmodule

/* rtl/cmd_fetch.sv */
`timescale 1ns/1ns

module cmd_fetch import cmd_pkg::*; (
	input  logic  CLOCK_50,
	input  logic  rst_n,
	// Host-to-fabric FIFO
	input  logic  rx_empty,
	output logic  rx_read,
	input  word_t rx_data,
	// Downstream link
	output logic  cmd_valid,
	input  logic  cmd_ready,
	output word_t cmd_data
);

	fetch_state_e state;
	fetch_state_e state_next;

	// Holding register can take a word
	// Either empty or handing its word over this cycle
	logic hold_free;

	assign hold_free = !cmd_valid || cmd_ready;

	// Read strobe is the whole READ state
	assign rx_read = (state == FETCH_READ);

	// ====================
	// Next state
	// ====================
	always_comb
	begin
		state_next = state;
		case (state)
			FETCH_IDLE:
			begin
				// Only start a read with room for the word
				if (!rx_empty && hold_free)
					state_next = FETCH_READ;
			end
			FETCH_READ:
				state_next = FETCH_LOAD;
			FETCH_LOAD:
				state_next = FETCH_IDLE;
			default:
				state_next = FETCH_IDLE;
		endcase
	end

	always_ff @(posedge CLOCK_50)
	begin
		if (!rst_n)
			state <= FETCH_IDLE;
		else
			state <= state_next;
	end

	// ====================
	// Holding register
	// ====================

	// FIFO shows the word one cycle after the strobe
	always_ff @(posedge CLOCK_50)
	begin
		if (state == FETCH_LOAD)
			cmd_data <= rx_data;
	end

	// Valid from the cycle after LOAD until taken
	always_ff @(posedge CLOCK_50)
	begin
		if (!rst_n)
			cmd_valid <= 1'b0;
		else if (state == FETCH_LOAD)
			cmd_valid <= 1'b1;
		else if (cmd_ready)
			cmd_valid <= 1'b0;
	end

	// No read from an empty FIFO
	a_read_not_empty: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		rx_read |-> !rx_empty);

	// Strobe is a single cycle
	a_read_pulse: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		rx_read |=> !rx_read);

endmodule

/* rtl/cmd_pkg.sv */
package cmd_pkg;

	// ====================
	// Data types
	// ====================

	// One FIFO word, both directions
	typedef logic [31:0] word_t;

	// Seven-segment pattern, active low
	// Bit 0 is segment a
	typedef logic [6:0] seg_t;

	// All segments dark
	localparam seg_t SEG_BLANK = 7'b1111111;

	// All segments lit
	localparam seg_t SEG_FULL = 7'b0000000;

	// ====================
	// Command codes
	// ====================

	// Host command words, compared against the full word
	typedef enum word_t {
		OP_DIGIT4_ON  = 32'd20,
		OP_DIGIT5_ON  = 32'd21,
		OP_DIGIT4_OFF = 32'd22,
		OP_DIGIT5_OFF = 32'd23
	} opcode_e;

	// Status words sent back for the commands
	// Entry 0 answers code 20, entry 3 answers code 23
	typedef word_t [3:0] status_arr_t;

	// ====================
	// Input side FSM
	// ====================

	// Idle, read strobe, load cycle
	typedef enum logic [1:0] {
		FETCH_IDLE = 2'd0,
		FETCH_READ = 2'd1,
		FETCH_LOAD = 2'd2
	} fetch_state_e;

endpackage

/* rtl/fifo_cmd_bridge.sv */
`timescale 1ns/1ns

module fifo_cmd_bridge import cmd_pkg::*; (
	input  logic        CLOCK_50,
	input  logic        rst_n,
	// Host-to-fabric FIFO
	input  logic        rx_empty,
	output logic        rx_read,
	input  word_t       rx_data,
	// Fabric-to-host FIFO
	output logic        tx_write,
	output word_t       tx_data,
	input  logic        tx_full,
	// Status words for the command replies
	input  status_arr_t status,
	// Indicators
	output seg_t        digit4,
	output seg_t        digit5,
	output logic        start_flag
);

	// ====================
	// Internal links
	// ====================

	// Fetch to decode
	logic  cmd_valid;
	logic  cmd_ready;
	word_t cmd_data;

	// Decode to write
	logic  reply_valid;
	logic  reply_ready;
	word_t reply_data;

	// Reads one word at a time from the host FIFO
	cmd_fetch i_cmd_fetch (
		.CLOCK_50  (CLOCK_50),
		.rst_n     (rst_n),
		.rx_empty  (rx_empty),
		.rx_read   (rx_read),
		.rx_data   (rx_data),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd_data  (cmd_data)
	);

	// Command decode and indicators
	cmd_decode i_cmd_decode (
		.CLOCK_50    (CLOCK_50),
		.rst_n       (rst_n),
		.cmd_valid   (cmd_valid),
		.cmd_ready   (cmd_ready),
		.cmd_data    (cmd_data),
		.status      (status),
		.reply_valid (reply_valid),
		.reply_ready (reply_ready),
		.reply_data  (reply_data),
		.digit4      (digit4),
		.digit5      (digit5),
		.start_flag  (start_flag)
	);

	// One reply buffered toward the host FIFO
	reply_write i_reply_write (
		.CLOCK_50    (CLOCK_50),
		.rst_n       (rst_n),
		.reply_valid (reply_valid),
		.reply_ready (reply_ready),
		.reply_data  (reply_data),
		.tx_write    (tx_write),
		.tx_data     (tx_data),
		.tx_full     (tx_full)
	);

endmodule

/* rtl/reply_write.sv */
`timescale 1ns/1ns

module reply_write import cmd_pkg::*; (
	input  logic  CLOCK_50,
	input  logic  rst_n,
	// From the decoder
	input  logic  reply_valid,
	output logic  reply_ready,
	input  word_t reply_data,
	// Fabric-to-host FIFO
	output logic  tx_write,
	output word_t tx_data,
	input  logic  tx_full
);

	// Holding register has a word waiting
	logic pending;

	// ====================
	// FIFO side
	// ====================

	// Hold off while the FIFO is full
	assign tx_write = pending && !tx_full;

	// Room when empty, or when the word leaves this cycle
	assign reply_ready = !pending || tx_write;

	// ====================
	// Holding register
	// ====================
	always_ff @(posedge CLOCK_50)
	begin
		if (reply_valid && reply_ready)
			tx_data <= reply_data;
	end

	// Refill on the write edge keeps one word per cycle
	always_ff @(posedge CLOCK_50)
	begin
		if (!rst_n)
			pending <= 1'b0;
		else if (reply_valid && reply_ready)
			pending <= 1'b1;
		else if (tx_write)
			pending <= 1'b0;
	end

	// Blocked word must not change under the FIFO
	a_hold_stable: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
		(pending && tx_full) |=> $stable(tx_data));

endmodule
